/* design/alu_config.svh */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// integer register width
`define ALU_XLEN 64

// commit tag carried alongside each op (rd)
`define ALU_TAG_W 5

// control word from the scheduler
// bit 5 and bits 2..0 op, bit 4 word mode, bit 3 alt
`define ALU_CTRL_W 6

// raw immediate field from decode, sign-extended in the issue stage
`define ALU_IMM_W 32

`endif

/* design/alu_pkg.sv */
`include "alu_config.svh"

package alu_pkg;

	// op code is {control[5], control[2:0]}
	typedef enum logic [3:0] {
		OP_ADD      = 4'd0,	// add / sub
		OP_XOR      = 4'd1,
		OP_AND      = 4'd2,
		OP_OR       = 4'd3,
		OP_SLT      = 4'd4,
		OP_SLTU     = 4'd5,
		OP_MIN      = 4'd6,	// min / minu
		OP_MAX      = 4'd7,	// max / maxu
		OP_SH1ADD   = 4'd9,
		OP_SH2ADD   = 4'd10,
		OP_SH3ADD   = 4'd11,
		OP_BITCOUNT = 4'd13	// clz / ctz / cpop, picked by the immediate
	} alu_op_e;

	// function select carried in the low immediate bits
	typedef enum logic [1:0] {
		BC_CLZ  = 2'd0,
		BC_CTZ  = 2'd1,
		BC_CPOP = 2'd2,
		BC_RSVD = 2'd3
	} bitcount_sel_e;

	typedef struct packed {
		logic [`ALU_IMM_W-3:0] unused;
		bitcount_sel_e         sel;
	} alu_bc_imm_s;

	// the same immediate word is an operand for most ops and a selector for bitcount
	typedef union packed {
		logic signed [`ALU_IMM_W-1:0] value;
		alu_bc_imm_s                  bc;
	} alu_immed_u;

endpackage

/* design/alu_decode.sv */
`include "alu_config.svh"

module alu_decode (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic                   makes_rd,
	input  logic                   needs_rs2,
	input  logic [`ALU_CTRL_W-1:0] control,
	input  logic [`ALU_TAG_W-1:0]  rd,
	input  logic [`ALU_XLEN-1:0]   r1,
	input  logic [`ALU_XLEN-1:0]   r2,
	input  alu_pkg::alu_immed_u    immed,
	output alu_pkg::alu_op_e       op,
	output logic                   word,
	output logic                   inv,
	output logic                   unsigned_cmp,
	output logic [`ALU_XLEN-1:0]   src1,
	output logic [`ALU_XLEN-1:0]   src2,
	output alu_pkg::alu_immed_u    imm_q,
	output logic [`ALU_TAG_W-1:0]  tag,
	output logic                   valid
);
	import alu_pkg::*;

	alu_op_e              op_in;
	logic                 alt;
	logic                 inv_in;
	logic [`ALU_XLEN-1:0] imm_ext;

	assign op_in = alu_op_e'({control[5], control[2:0]});
	assign alt = control[3];
	assign imm_ext = {{(`ALU_XLEN-`ALU_IMM_W){immed.value[`ALU_IMM_W-1]}}, immed.value};

	always_comb begin
		case (op_in)
			OP_ADD, OP_XOR, OP_AND, OP_OR: inv_in = alt;	// sub, xnor, andn, orn
			OP_SLT, OP_SLTU, OP_MIN, OP_MAX: inv_in = 1'b1;	// compares need r1 - r2
			default: inv_in = 1'b0;
		endcase
	end

	// issue registers, payload only
	always_ff @(posedge clk) begin
		op <= op_in;
		word <= control[4];
		inv <= inv_in;
		unsigned_cmp <= alt;	// only min/max look at it
		src1 <= r1;
		src2 <= needs_rs2 ? r2 : imm_ext;
		imm_q <= immed;
		tag <= rd;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else begin
			valid <= makes_rd & enable;
		end
	end

	// scheduler must never issue a hole in the op map
	assert property (@(posedge clk) disable iff (!rst_n)
		enable |-> !(op_in inside {4'd8, 4'd12, 4'd14, 4'd15}))
		else $error("reserved alu op issued");

	// the bitcount unit has no encoding for select 3
	assert property (@(posedge clk) disable iff (!rst_n)
		(valid && op == OP_BITCOUNT) |-> imm_q.bc.sel != BC_RSVD)
		else $error("reserved bitcount select reached the execute stage");

endmodule

/* design/alu_execute.sv */
`include "alu_config.svh"

module alu_execute (
	input  alu_pkg::alu_op_e     op,
	input  logic                 word,
	input  logic                 inv,
	input  logic                 unsigned_cmp,
	input  logic [`ALU_XLEN-1:0] src1,
	input  logic [`ALU_XLEN-1:0] src2,
	output logic [`ALU_XLEN-1:0] sum,
	output logic [`ALU_XLEN-1:0] logic_res,
	output logic                 lt,
	output logic [`ALU_XLEN-1:0] minmax
);
	import alu_pkg::*;

	localparam int MSB = `ALU_XLEN - 1;

	logic [`ALU_XLEN-1:0] base;	// src1, or its zero-extended low word
	logic [`ALU_XLEN-1:0] opa;
	logic [`ALU_XLEN-1:0] opb;
	logic [`ALU_XLEN:0]   add_full;
	logic                 carry;
	logic                 s_lt;
	logic                 u_lt;
	logic                 use_unsigned;

	// first adder operand, shNadd and shNadd.uw shaping
	always_comb begin
		base = word ? {{(`ALU_XLEN-32){1'b0}}, src1[31:0]} : src1;
		case (op)
			OP_SH1ADD: opa = base << 1;
			OP_SH2ADD: opa = base << 2;
			OP_SH3ADD: opa = base << 3;
			default:   opa = src1;
		endcase
	end

	assign opb = inv ? ~src2 : src2;

	// single adder, carry-in completes the two's complement
	assign add_full = {1'b0, opa} + {1'b0, opb} + {{`ALU_XLEN{1'b0}}, inv};
	assign sum = add_full[MSB:0];
	assign carry = add_full[`ALU_XLEN];

	// signs differ means the answer is r1's sign, else the difference sign
	assign s_lt = (opa[MSB] ^ src2[MSB]) ? opa[MSB] : sum[MSB];
	assign u_lt = ~carry;	// no carry out of r1 + ~r2 + 1 means borrow

	always_comb begin
		case (op)
			OP_SLTU: use_unsigned = 1'b1;
			OP_MIN, OP_MAX: use_unsigned = unsigned_cmp;
			default: use_unsigned = 1'b0;
		endcase
	end

	assign lt = use_unsigned ? u_lt : s_lt;

	always_comb begin
		if (op == OP_MAX) begin
			minmax = lt ? src2 : src1;
		end else begin
			minmax = lt ? src1 : src2;
		end
	end

	// opb is already inverted for xnor/andn/orn
	always_comb begin
		case (op)
			OP_XOR:  logic_res = src1 ^ opb;
			OP_AND:  logic_res = src1 & opb;
			OP_OR:   logic_res = src1 | opb;
			default: logic_res = '0;
		endcase
	end

endmodule

/* design/alu_bitcount.sv */
`include "alu_config.svh"

module alu_bitcount (
	input  logic [`ALU_XLEN-1:0]  src1,
	input  logic                  word,
	input  alu_pkg::bitcount_sel_e sel,
	output logic [6:0]            count
);
	import alu_pkg::*;

	// zeros above the first set bit of a nonzero nibble
	function automatic logic [1:0] lead4(input logic [3:0] n);
		casez (n)
			4'b1???: lead4 = 2'd0;
			4'b01??: lead4 = 2'd1;
			4'b001?: lead4 = 2'd2;
			default: lead4 = 2'd3;
		endcase
	endfunction

	function automatic logic [1:0] trail4(input logic [3:0] n);
		casez (n)
			4'b???1: trail4 = 2'd0;
			4'b??10: trail4 = 2'd1;
			4'b?100: trail4 = 2'd2;
			default: trail4 = 2'd3;
		endcase
	endfunction

	logic [15:0] nib_zero;
	logic [1:0]  nib_lead [16];
	logic [1:0]  nib_trail [16];
	logic [2:0]  nib_pop [16];
	logic [5:0]  lz [2];	// per 32-bit half, 0..32
	logic [5:0]  tz [2];
	logic [5:0]  pop [2];
	logic        hi_zero;
	logic        lo_zero;

	always_comb begin
		for (int i = 0; i < 16; i++) begin
			nib_zero[i] = (src1[4*i +: 4] == 4'b0);
			nib_lead[i] = lead4(src1[4*i +: 4]);
			nib_trail[i] = trail4(src1[4*i +: 4]);
			nib_pop[i] = {2'b0, src1[4*i]} + {2'b0, src1[4*i+1]} +
				{2'b0, src1[4*i+2]} + {2'b0, src1[4*i+3]};
		end
	end

	always_comb begin
		for (int h = 0; h < 2; h++) begin
			lz[h] = 6'd32;
			tz[h] = 6'd32;
			pop[h] = 6'd0;
			for (int i = 0; i < 8; i++) begin	// last hit is the highest set nibble
				if (!nib_zero[8*h+i])
					lz[h] = {1'b0, 3'(7 - i), nib_lead[8*h+i]};
				pop[h] = pop[h] + {3'b0, nib_pop[8*h+i]};
			end
			for (int i = 7; i >= 0; i--) begin	// last hit is the lowest set nibble
				if (!nib_zero[8*h+i])
					tz[h] = {1'b0, 3'(i), nib_trail[8*h+i]};
			end
		end
	end

	assign hi_zero = &nib_zero[15:8];
	assign lo_zero = &nib_zero[7:0];

	always_comb begin
		case (sel)
			BC_CLZ:  count = (word || !hi_zero) ? (word ? {1'b0, lz[0]} : {1'b0, lz[1]}) :
				7'd32 + {1'b0, lz[0]};
			BC_CTZ:  count = (word || !lo_zero) ? {1'b0, tz[0]} : 7'd32 + {1'b0, tz[1]};
			BC_CPOP: count = word ? {1'b0, pop[0]} : {1'b0, pop[0]} + {1'b0, pop[1]};
			default: count = 7'd0;
		endcase
	end

endmodule

/* design/alu_result.sv */
`include "alu_config.svh"

module alu_result (
	input  logic                  clk,
	input  logic                  rst_n,
	input  alu_pkg::alu_op_e      op,
	input  logic                  word,
	input  logic                  valid,
	input  logic [`ALU_TAG_W-1:0] tag,
	input  logic [`ALU_XLEN-1:0]  sum,
	input  logic [`ALU_XLEN-1:0]  logic_res,
	input  logic                  lt,
	input  logic [`ALU_XLEN-1:0]  minmax,
	input  logic [6:0]            count,
	output logic [`ALU_XLEN-1:0]  result,
	output logic [`ALU_TAG_W-1:0] res_rd,
	output logic                  res_makes_rd
);
	import alu_pkg::*;

	logic [`ALU_XLEN-1:0] c_res;

	always_comb begin
		case (op)
			OP_ADD: c_res = word ? {{(`ALU_XLEN-32){sum[31]}}, sum[31:0]} : sum;	// addw/subw
			OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: c_res = sum;	// .uw forms stay 64-bit
			OP_XOR, OP_AND, OP_OR: c_res = logic_res;
			OP_SLT, OP_SLTU: c_res = {{(`ALU_XLEN-1){1'b0}}, lt};
			OP_MIN, OP_MAX: c_res = minmax;
			OP_BITCOUNT: c_res = {{(`ALU_XLEN-7){1'b0}}, count};
			default: c_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		result <= c_res;
		res_rd <= tag;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_makes_rd <= 1'b0;
		end else begin
			res_makes_rd <= valid;
		end
	end

	// writeback strobe must be clean once out of reset
	assert property (@(posedge clk) rst_n |-> !$isunknown(res_makes_rd))
		else $error("res_makes_rd unknown after reset");

endmodule

/* design/alu_top.sv */
`include "alu_config.svh"

module alu_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [`ALU_CTRL_W-1:0] control,
	input  logic [`ALU_TAG_W-1:0]  rd,
	input  logic                   makes_rd,
	input  logic                   needs_rs2,
	input  logic [`ALU_XLEN-1:0]   r1,
	input  logic [`ALU_XLEN-1:0]   r2,
	input  alu_pkg::alu_immed_u    immed,
	output logic [`ALU_XLEN-1:0]   result,
	output logic [`ALU_TAG_W-1:0]  res_rd,
	output logic                   res_makes_rd
);
	import alu_pkg::*;

	// issue stage registers
	alu_op_e               op;
	logic                  word;
	logic                  inv;
	logic                  unsigned_cmp;
	logic [`ALU_XLEN-1:0]  src1;
	logic [`ALU_XLEN-1:0]  src2;
	alu_immed_u            imm_q;
	logic [`ALU_TAG_W-1:0] tag;
	logic                  valid;

	// execute outputs
	logic [`ALU_XLEN-1:0]  sum;
	logic [`ALU_XLEN-1:0]  logic_res;
	logic                  lt;
	logic [`ALU_XLEN-1:0]  minmax;
	logic [6:0]            count;

	alu_decode decode_i (
		.clk, .rst_n, .enable, .makes_rd, .needs_rs2, .control, .rd, .r1, .r2, .immed,
		.op, .word, .inv, .unsigned_cmp, .src1, .src2, .imm_q, .tag, .valid
	);

	alu_execute execute_i (
		.op, .word, .inv, .unsigned_cmp, .src1, .src2,
		.sum, .logic_res, .lt, .minmax
	);

	alu_bitcount bitcount_i (
		.src1, .word,
		.sel   (imm_q.bc.sel),	// immediate doubles as the function select
		.count
	);

	alu_result result_i (
		.clk, .rst_n, .op, .word, .valid, .tag, .sum, .logic_res, .lt, .minmax, .count,
		.result, .res_rd, .res_makes_rd
	);

endmodule

/* dv/alu_checker.sv */
`include "alu_config.svh"

module alu_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   enable,
	input  logic [`ALU_CTRL_W-1:0] control,
	input  logic [`ALU_TAG_W-1:0]  rd,
	input  logic                   makes_rd,
	input  logic                   needs_rs2,
	input  logic [`ALU_XLEN-1:0]   r1,
	input  logic [`ALU_XLEN-1:0]   r2,
	input  logic [`ALU_IMM_W-1:0]  immed,
	input  logic [`ALU_XLEN-1:0]   result,
	input  logic [`ALU_TAG_W-1:0]  res_rd,
	input  logic                   res_makes_rd,
	output int                     error_count,
	output int                     results_seen
);
	import alu_pkg::*;

	int errors = 0;
	int seen = 0;
	int cycles = 0;

	// two-deep expectation pipe, s2 lines up with the DUT outputs
	logic                  s1_valid = 1'b0;
	logic                  s2_valid = 1'b0;
	logic [`ALU_TAG_W-1:0] s1_rd;
	logic [`ALU_TAG_W-1:0] s2_rd;
	logic [3:0]            s1_op;
	logic [3:0]            s2_op;
	logic [`ALU_XLEN-1:0]  s1_res;
	logic [`ALU_XLEN-1:0]  s2_res;

	assign error_count = errors;
	assign results_seen = seen;

	// bit by bit, n is 32 in word mode
	function automatic logic [6:0] expected_count(input logic [63:0] v, input logic word,
		input logic [1:0] sel);
		int n;
		int lead;
		int trail;
		int pop;
		n = word ? 32 : 64;
		lead = n;
		trail = n;
		pop = 0;
		for (int i = 0; i < n; i++) begin
			if (v[i]) begin
				pop++;
				if (trail == n)
					trail = i;	// first set bit from the bottom
				lead = n - 1 - i;	// last one wins, highest set bit
			end
		end
		case (sel)
			2'd0: return 7'(lead);
			2'd1: return 7'(trail);
			default: return 7'(pop);
		endcase
	endfunction

	function automatic logic [63:0] expected_result(input logic [5:0] ctrl, input logic use_rs2,
		input logic [63:0] a, input logic [63:0] r2v, input logic [31:0] imm);
		logic [3:0]         op;
		logic               word;
		logic               alt;
		logic               uns;
		logic               lt;
		logic [63:0]        b;
		logic [63:0]        nb;
		logic [63:0]        base;
		logic [63:0]        t;
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		op = {ctrl[5], ctrl[2:0]};
		word = ctrl[4];
		alt = ctrl[3];
		b = use_rs2 ? r2v : {{32{imm[31]}}, imm};
		nb = alt ? ~b : b;
		base = word ? {32'b0, a[31:0]} : a;	// .uw forms
		sa = a;
		sb = b;
		uns = (op == OP_SLTU) || ((op == OP_MIN || op == OP_MAX) && alt);
		lt = uns ? (a < b) : (sa < sb);
		case (op)
			OP_ADD: begin
				t = alt ? a - b : a + b;
				return word ? {{32{t[31]}}, t[31:0]} : t;
			end
			OP_XOR: return a ^ nb;
			OP_AND: return a & nb;
			OP_OR: return a | nb;
			OP_SLT, OP_SLTU: return {63'b0, lt};
			OP_MIN: return lt ? a : b;
			OP_MAX: return lt ? b : a;
			OP_SH1ADD: return (base << 1) + b;
			OP_SH2ADD: return (base << 2) + b;
			OP_SH3ADD: return (base << 3) + b;
			OP_BITCOUNT: return {57'b0, expected_count(a, word, imm[1:0])};
			default: return 64'b0;
		endcase
	endfunction

	always @(posedge clk) begin
		s2_valid = s1_valid;
		s2_rd = s1_rd;
		s2_op = s1_op;
		s2_res = s1_res;
		s1_valid = rst_n && enable && makes_rd;
		s1_rd = rd;
		s1_op = {control[5], control[2:0]};
		s1_res = expected_result(control, needs_rs2, r1, r2, immed);
	end

	// outputs settle after the rising edge, look at them half a cycle later
	always @(negedge clk) begin
		cycles++;
		if (res_makes_rd !== s2_valid) begin
			errors++;
			$display("ERROR %0t: res_makes_rd is %b, expected %b", $time, res_makes_rd, s2_valid);
		end else if (s2_valid) begin
			seen++;
			if (res_rd !== s2_rd) begin
				errors++;
				$display("ERROR %0t: res_rd is %0d, expected %0d", $time, res_rd, s2_rd);
			end
			if (result !== s2_res) begin
				errors++;
				$display("ERROR %0t: op %0d tag %0d result %h, expected %h",
					$time, s2_op, s2_rd, result, s2_res);
			end
		end
	end

	task automatic print_summary();
		$display("alu_checker: %0d cycles, %0d results, %0d errors", cycles, seen, errors);
	endtask

endmodule

/* dv/alu_tb.sv */
`include "alu_config.svh"

module alu_tb;
	import alu_pkg::*;

	localparam int NUM_OPS = 2000;
	localparam int DRAIN_LIMIT = 50;	// cycles

	logic                   clk;
	logic                   rst_n;
	logic                   enable;
	logic                   makes_rd;
	logic                   needs_rs2;
	logic [`ALU_CTRL_W-1:0] control;
	logic [`ALU_TAG_W-1:0]  rd;
	logic [`ALU_XLEN-1:0]   r1;
	logic [`ALU_XLEN-1:0]   r2;
	alu_immed_u             immed;
	logic [`ALU_XLEN-1:0]   result;
	logic [`ALU_TAG_W-1:0]  res_rd;
	logic                   res_makes_rd;

	int          error_count;
	int          results_seen;
	int          writes_issued;
	logic        drained;
	logic [63:0] lcg_state;
	logic [3:0]  op_table [12];	// defined codes only

	alu_top dut_i (
		.clk, .rst_n, .enable, .control, .rd, .makes_rd, .needs_rs2, .r1, .r2, .immed,
		.result, .res_rd, .res_makes_rd
	);

	alu_checker checker_i (
		.clk, .rst_n, .enable, .control, .rd, .makes_rd, .needs_rs2, .r1, .r2, .immed,
		.result, .res_rd, .res_makes_rd, .error_count, .results_seen
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state[63:32];	// upper bits are the good ones
	endfunction

	// skewed shapes so the bit counts see long zero runs
	function automatic logic [63:0] rand_operand();
		logic [63:0] v;
		logic [31:0] r;
		v = {next_rand(), next_rand()};
		r = next_rand();
		case (r[2:0])
			3'd0: v = '0;
			3'd1: v = v >> r[8:3];
			3'd2: v = v << r[8:3];
			3'd3: v = {v[63:32], 32'b0};	// empty low word
			default: ;
		endcase
		return v;
	endfunction

	task automatic drive_op(input logic active);
		logic [31:0] f;
		logic [3:0]  op;
		int          idx;
		f = next_rand();
		idx = int'(next_rand() % 32'd12);
		op = op_table[idx];
		enable = active;
		control = {op[3], f[0], f[1], op[2:0]};	// op, word, alt
		makes_rd = (f[10:8] != 3'd0);
		needs_rs2 = f[11];
		rd = f[12 +: `ALU_TAG_W];
		r1 = rand_operand();
		r2 = (f[19:17] == 3'd0) ? r1 : rand_operand();
		immed.value = next_rand();
		if (op == OP_BITCOUNT)
			immed.bc.sel = bitcount_sel_e'((f[25:24] == 2'd3) ? 2'd2 : f[25:24]);
		if (active && makes_rd)
			writes_issued++;
	endtask

	initial begin
		int issued;
		issued = 0;
		lcg_state = 64'd79978;
		op_table = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd9, 4'd10, 4'd11, 4'd13};
		clk = 1'b0;
		rst_n = 1'b0;
		enable = 1'b1;	// ops offered during reset must not come out
		makes_rd = 1'b1;
		needs_rs2 = 1'b0;
		control = '0;
		rd = '0;
		r1 = '0;
		r2 = '0;
		immed = '0;
		writes_issued = 0;
		drained = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		enable = 1'b0;
		makes_rd = 1'b0;

		while (issued < NUM_OPS) begin
			@(negedge clk);
			if (next_rand() % 32'd8 == 32'd0) begin
				drive_op(1'b0);	// idle slot
			end else begin
				drive_op(1'b1);
				issued++;
			end
		end
		@(negedge clk);
		enable = 1'b0;
		makes_rd = 1'b0;

		for (int i = 0; i < DRAIN_LIMIT && !drained; i++) begin
			@(posedge clk);
			drained = (results_seen == writes_issued);
		end
		if (!drained)
			$display("timeout: %0d of %0d results came back within %0d cycles",
				results_seen, writes_issued, DRAIN_LIMIT);
		checker_i.print_summary();
		if (drained && error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

/* alu_top.f */
+incdir+design
design/alu_pkg.sv
design/alu_decode.sv
design/alu_execute.sv
design/alu_bitcount.sv
design/alu_result.sv
design/alu_top.sv
dv/alu_checker.sv
dv/alu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module alu_tb -f alu_top.f -o alu_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/alu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^PASS: all tests$"; then
	exit 0
fi
exit 1
